//--- fbmem_pkg.sv
// Shared word types, arbiter client count and client index constants
package fbmem_pkg;

// Word address and data widths
localparam int ADDR_W = 12;
localparam int DATA_W = 16;

typedef logic [ADDR_W-1:0] addr_t;
typedef logic [DATA_W-1:0] data_t;

// Arbiter clients, lower index wins a tie after reset
localparam int N_CLIENTS = 3;
localparam int CL_RECT = 0;
localparam int CL_TEST = 1;
localparam int CL_EXT = 2;

endpackage

//--- mem_store.sv
// Single-port word memory with single writes and fixed-latency burst reads
module mem_store import fbmem_pkg::*; #(
	parameter int BURST = 8
) (
	input logic CLOCK_50,
	input logic rst,
	input logic m_en,
	input logic m_wr,
	input addr_t m_addr,
	input data_t m_wdata,
	output data_t m_rdata,
	output logic m_rvalid
);

localparam int DEPTH = 2 ** ADDR_W;
localparam int CNT_W = $clog2(BURST + 1);

// Contents start out cleared
data_t mem [DEPTH] = '{default: '0};

addr_t rd_addr;
logic [CNT_W-1:0] rd_left;

// RAM array with registered read port
always_ff @(posedge CLOCK_50) begin
	if (m_en && m_wr)
		mem[m_addr] <= m_wdata;
	m_rdata <= mem[rd_addr];
end

// Burst sequencing, first word two cycles after the request
always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		rd_left <= '0;
		m_rvalid <= 1'b0;
	end else begin
		m_rvalid <= rd_left != '0;
		if (m_en && !m_wr)
			rd_left <= CNT_W'(BURST);
		else if (rd_left != '0)
			rd_left <= rd_left - 1'b1;
	end
end

always_ff @(posedge CLOCK_50) begin
	if (m_en && !m_wr)
		rd_addr <= m_addr;
	else if (rd_left != '0)
		rd_addr <= rd_addr + 1'b1;
end

// Arbiter must hold off while a burst streams out
a_no_en_in_burst: assert property (@(posedge CLOCK_50) disable iff (rst)
	rd_left != '0 |-> !m_en);

endmodule

//--- mem_arbiter.sv
// Round-robin memory arbiter with per-client acknowledge and read-valid routing
module mem_arbiter import fbmem_pkg::*; #(
	parameter int BURST = 8
) (
	input logic CLOCK_50,
	input logic rst,
	input logic [N_CLIENTS-1:0] req,
	input logic [N_CLIENTS-1:0] wr,
	input addr_t addr [N_CLIENTS],
	input data_t wdata [N_CLIENTS],
	output logic [N_CLIENTS-1:0] ack,
	output logic [N_CLIENTS-1:0] rvalid,
	output logic m_en,
	output logic m_wr,
	output addr_t m_addr,
	output data_t m_wdata,
	input logic m_rvalid
);

localparam int IDX_W = $clog2(N_CLIENTS);
localparam int BEAT_W = $clog2(BURST + 1);

typedef enum logic {S_IDLE, S_BURST} state_t;

state_t state;
logic [IDX_W-1:0] last;
logic [IDX_W-1:0] owner;
logic [IDX_W-1:0] win;
logic found;
logic grant;
logic [BEAT_W-1:0] beat;

// Search starts at the client after the last one granted
always_comb begin
	int idx;
	found = 1'b0;
	win = '0;
	for (int k = 1; k <= N_CLIENTS; k++) begin
		idx = (int'(last) + k) % N_CLIENTS;
		if (!found && req[idx]) begin
			found = 1'b1;
			win = IDX_W'(idx);
		end
	end
end

// No new grant during an ack cycle, the client still holds req then
assign grant = state == S_IDLE && ack == '0 && found;

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= S_IDLE;
		last <= IDX_W'(N_CLIENTS - 1);
		owner <= '0;
		beat <= '0;
		ack <= '0;
		m_en <= 1'b0;
	end else begin
		ack <= '0;
		m_en <= 1'b0;
		case (state)
			S_IDLE: begin
				if (grant) begin
					ack[win] <= 1'b1;
					m_en <= 1'b1;
					last <= win;
					owner <= win;
					beat <= '0;
					if (!wr[win])
						state <= S_BURST;
				end
			end
			S_BURST: begin
				// Free again in the cycle after the last word
				if (m_rvalid) begin
					beat <= beat + 1'b1;
					if (beat == BEAT_W'(BURST - 1))
						state <= S_IDLE;
				end
			end
			default: state <= S_IDLE;
		endcase
	end
end

// Access payload toward the store
always_ff @(posedge CLOCK_50) begin
	if (grant) begin
		m_wr <= wr[win];
		m_addr <= addr[win];
		m_wdata <= wdata[win];
	end
end

// Read data goes to whoever owns the burst
always_comb begin
	for (int i = 0; i < N_CLIENTS; i++)
		rvalid[i] = m_rvalid && owner == IDX_W'(i);
end

a_ack_onehot: assert property (@(posedge CLOCK_50) disable iff (rst) $onehot0(ack));

// Clients hold req until they see their ack
a_ack_to_req: assert property (@(posedge CLOCK_50) disable iff (rst) (ack & ~req) == '0);

endmodule

//--- rect_fill.sv
// Rectangle fill engine writing a latched colour into the frame buffer
module rect_fill import fbmem_pkg::*; #(
	parameter addr_t FB_BASE = '0,
	parameter int LINE_W = 64,
	parameter int RECT_X = 0,
	parameter int RECT_Y = 0,
	parameter int RECT_W = 16,
	parameter int RECT_H = 8
) (
	input logic CLOCK_50,
	input logic rst,
	input logic start,
	input data_t color,
	output logic req,
	output logic wr,
	output addr_t addr,
	output data_t wdata,
	input logic ack,
	output logic active
);

// Top-left pixel of the rectangle
localparam addr_t FIRST = addr_t'(int'(FB_BASE) + RECT_Y * LINE_W + RECT_X);

typedef enum logic {S_IDLE, S_FILL} state_t;

state_t state;
data_t fill_color;
logic [ADDR_W-1:0] col;
logic [ADDR_W-1:0] row;
addr_t line_addr;
addr_t pix_addr;
logic last_col;
logic last_pix;

assign active = state == S_FILL;
assign req = state == S_FILL;
// Write-only client
assign wr = 1'b1;
assign addr = pix_addr;
assign wdata = fill_color;

assign last_col = col == ADDR_W'(RECT_W - 1);
assign last_pix = last_col && row == ADDR_W'(RECT_H - 1);

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= S_IDLE;
		col <= '0;
		row <= '0;
	end else begin
		case (state)
			S_IDLE: begin
				if (start) begin
					state <= S_FILL;
					col <= '0;
					row <= '0;
				end
			end
			S_FILL: begin
				if (ack) begin
					if (last_pix)
						state <= S_IDLE;
					if (last_col) begin
						col <= '0;
						row <= row + 1'b1;
					end else begin
						col <= col + 1'b1;
					end
				end
			end
			default: state <= S_IDLE;
		endcase
	end
end

// Running line base, no multiplier
always_ff @(posedge CLOCK_50) begin
	if (state == S_IDLE && start) begin
		fill_color <= color;
		line_addr <= FIRST;
		pix_addr <= FIRST;
	end else if (state == S_FILL && ack) begin
		if (last_col) begin
			line_addr <= line_addr + addr_t'(LINE_W);
			pix_addr <= line_addr + addr_t'(LINE_W);
		end else begin
			pix_addr <= pix_addr + 1'b1;
		end
	end
end

endmodule

//--- mem_test.sv
// Memory self-test client, pattern write then burst read-back and compare
module mem_test import fbmem_pkg::*; #(
	parameter int BURST = 8,
	parameter addr_t TEST_BASE = '0,
	parameter int TEST_LEN = 64
) (
	input logic CLOCK_50,
	input logic rst,
	input logic start,
	input data_t seed,
	output logic req,
	output logic wr,
	output addr_t addr,
	output data_t wdata,
	input logic ack,
	input data_t rdata,
	input logic rvalid,
	output logic done,
	output logic fail
);

// Last word of the test region
localparam addr_t LAST = addr_t'(int'(TEST_BASE) + TEST_LEN - 1);
localparam int BEAT_W = $clog2(BURST + 1);

typedef enum logic [1:0] {S_IDLE, S_WRITE, S_READ, S_WAIT} state_t;

state_t state;
data_t seed_r;
addr_t iss_addr;
addr_t cmp_addr;
logic [BEAT_W-1:0] beat;
logic last_beat;

// Address-derived test word
function automatic data_t pattern(addr_t a, data_t s);
	return data_t'(a) ^ s;
endfunction

assign req = state == S_WRITE || state == S_READ;
assign wr = state == S_WRITE;
assign addr = iss_addr;
assign wdata = pattern(iss_addr, seed_r);
assign last_beat = beat == BEAT_W'(BURST - 1);

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= S_IDLE;
		beat <= '0;
		done <= 1'b0;
		fail <= 1'b0;
	end else begin
		case (state)
			S_IDLE: begin
				if (start) begin
					state <= S_WRITE;
					done <= 1'b0;
					fail <= 1'b0;
				end
			end
			S_WRITE: begin
				if (ack && iss_addr == LAST)
					state <= S_READ;
			end
			S_READ: begin
				if (ack) begin
					state <= S_WAIT;
					beat <= '0;
				end
			end
			S_WAIT: begin
				if (rvalid) begin
					// Mismatch stays flagged until the next start
					if (rdata != pattern(cmp_addr, seed_r))
						fail <= 1'b1;
					beat <= beat + 1'b1;
					if (last_beat) begin
						if (cmp_addr == LAST) begin
							done <= 1'b1;
							state <= S_IDLE;
						end else begin
							state <= S_READ;
						end
					end
				end
			end
			default: state <= S_IDLE;
		endcase
	end
end

// Issue and compare addresses
always_ff @(posedge CLOCK_50) begin
	if (state == S_IDLE && start) begin
		seed_r <= seed;
		iss_addr <= TEST_BASE;
	end else if (state == S_WRITE && ack) begin
		iss_addr <= (iss_addr == LAST) ? TEST_BASE : iss_addr + 1'b1;
	end else if (state == S_READ && ack) begin
		cmp_addr <= iss_addr;
	end else if (state == S_WAIT && rvalid) begin
		cmp_addr <= cmp_addr + 1'b1;
		if (last_beat)
			iss_addr <= iss_addr + addr_t'(BURST);
	end
end

endmodule

//--- fbmem_top.sv
// Frame buffer memory subsystem top with store, arbiter and clients
module fbmem_top import fbmem_pkg::*; #(
	parameter int BURST = 8,
	parameter addr_t FB_BASE = 12'h000,
	parameter int LINE_W = 64,
	parameter int RECT_X = 8,
	parameter int RECT_Y = 4,
	parameter int RECT_W = 16,
	parameter int RECT_H = 8,
	parameter addr_t TEST_BASE = 12'h800,
	parameter int TEST_LEN = 64
) (
	input logic CLOCK_50,
	input logic rst,
	input logic rect_start,
	input data_t rect_color,
	output logic rect_active,
	input logic test_start,
	input data_t test_seed,
	output logic test_done,
	output logic test_fail,
	input logic ext_req,
	input addr_t ext_addr,
	output logic ext_ack,
	output data_t ext_rdata,
	output logic ext_rvalid
);

// Client side of the arbiter
logic [N_CLIENTS-1:0] cl_req;
logic [N_CLIENTS-1:0] cl_wr;
logic [N_CLIENTS-1:0] cl_ack;
logic [N_CLIENTS-1:0] cl_rvalid;
addr_t cl_addr [N_CLIENTS];
data_t cl_wdata [N_CLIENTS];

// Memory side
logic m_en;
logic m_wr;
addr_t m_addr;
data_t m_wdata;
data_t m_rdata;
logic m_rvalid;

mem_store #(.BURST(BURST)) store_i (
	.CLOCK_50(CLOCK_50), .rst(rst),
	.m_en(m_en), .m_wr(m_wr), .m_addr(m_addr), .m_wdata(m_wdata),
	.m_rdata(m_rdata), .m_rvalid(m_rvalid)
);

mem_arbiter #(.BURST(BURST)) arb_i (
	.CLOCK_50(CLOCK_50), .rst(rst),
	.req(cl_req), .wr(cl_wr), .addr(cl_addr), .wdata(cl_wdata),
	.ack(cl_ack), .rvalid(cl_rvalid),
	.m_en(m_en), .m_wr(m_wr), .m_addr(m_addr), .m_wdata(m_wdata),
	.m_rvalid(m_rvalid)
);

rect_fill #(
	.FB_BASE(FB_BASE), .LINE_W(LINE_W),
	.RECT_X(RECT_X), .RECT_Y(RECT_Y), .RECT_W(RECT_W), .RECT_H(RECT_H)
) rect_i (
	.CLOCK_50(CLOCK_50), .rst(rst),
	.start(rect_start), .color(rect_color),
	.req(cl_req[CL_RECT]), .wr(cl_wr[CL_RECT]),
	.addr(cl_addr[CL_RECT]), .wdata(cl_wdata[CL_RECT]),
	.ack(cl_ack[CL_RECT]), .active(rect_active)
);

mem_test #(.BURST(BURST), .TEST_BASE(TEST_BASE), .TEST_LEN(TEST_LEN)) test_i (
	.CLOCK_50(CLOCK_50), .rst(rst),
	.start(test_start), .seed(test_seed),
	.req(cl_req[CL_TEST]), .wr(cl_wr[CL_TEST]),
	.addr(cl_addr[CL_TEST]), .wdata(cl_wdata[CL_TEST]),
	.ack(cl_ack[CL_TEST]), .rdata(m_rdata), .rvalid(cl_rvalid[CL_TEST]),
	.done(test_done), .fail(test_fail)
);

// External scan-out port, read only
assign cl_req[CL_EXT] = ext_req;
assign cl_wr[CL_EXT] = 1'b0;
assign cl_addr[CL_EXT] = ext_addr;
assign cl_wdata[CL_EXT] = '0;
assign ext_ack = cl_ack[CL_EXT];
assign ext_rvalid = cl_rvalid[CL_EXT];
assign ext_rdata = m_rdata;

endmodule

//--- tb_clock.sv
// Testbench clock generator and synchronous reset sequence
module tb_clock (
	output logic CLOCK_50,
	output logic rst
);

timeunit 1ns;
timeprecision 1ps;

// 8 ns period
initial CLOCK_50 = 1'b0;
always #4 CLOCK_50 = ~CLOCK_50;

// Reset held over the first three rising edges
initial begin
	rst = 1'b1;
	repeat (3) @(posedge CLOCK_50);
	rst <= 1'b0;
end

endmodule

//--- tb_checker.sv
// Testbench monitor for external read data, read timing and status outputs
module tb_checker import fbmem_pkg::*; #(
	parameter int BURST = 8
) (
	input logic CLOCK_50,
	input logic rst,
	input logic ext_ack,
	input logic ext_rvalid,
	input data_t ext_rdata,
	input logic rect_active,
	input logic test_done,
	input logic test_fail,
	input logic exp_load,
	input logic [BURST*DATA_W-1:0] exp_burst,
	input logic stat_chk,
	input logic exp_active,
	input logic exp_done,
	input logic exp_fail,
	input logic end_chk,
	output int err_count
);

timeunit 1ns;
timeprecision 1ps;

// Expected read words in arrival order
data_t exp_q [$];
// Cycles since the last ext_ack or -1 when no burst is due
int offs = -1;
logic seen_run = 1'b0;

initial err_count = 0;

task automatic report_value(string name, data_t exp, data_t got);
	$display("ERR %s exp %h got %h", name, exp, got);
	err_count++;
endtask

task automatic report_fault(string msg);
	$display("%s", msg);
	err_count++;
endtask

task automatic compare_bit(string name, logic exp, logic got);
	if (got !== exp)
		report_value(name, data_t'(exp), data_t'(got));
endtask

always @(posedge CLOCK_50) begin
	logic [BURST*DATA_W-1:0] words;
	data_t exp_word;
	logic exp_rv;
	if (rst) begin
		offs = -1;
		exp_q.delete();
	end else begin
		// Everything quiet right after reset
		if (!seen_run) begin
			seen_run = 1'b1;
			if ({rect_active, test_done, test_fail, ext_ack, ext_rvalid} !== 5'b0)
				report_fault("status or handshake output high right after reset");
		end
		if (exp_load) begin
			words = exp_burst;
			for (int i = 0; i < BURST; i++) begin
				exp_q.push_back(words[DATA_W-1:0]);
				words = words >> DATA_W;
			end
		end
		// Data is due two cycles after the ack and lasts BURST cycles
		if (ext_ack)
			offs = 0;
		else if (offs >= 0)
			offs++;
		exp_rv = offs >= 2 && offs <= BURST + 1;
		compare_bit("ext_rvalid", exp_rv, ext_rvalid);
		if (offs == BURST + 1)
			offs = -1;
		if (ext_rvalid === 1'b1) begin
			if (exp_q.size() == 0) begin
				report_fault("external read word arrived with no read outstanding");
			end else begin
				exp_word = exp_q.pop_front();
				if (ext_rdata !== exp_word)
					report_value("ext_rdata", exp_word, ext_rdata);
			end
		end
		if (stat_chk) begin
			compare_bit("rect_active", exp_active, rect_active);
			compare_bit("test_done", exp_done, test_done);
			compare_bit("test_fail", exp_fail, test_fail);
		end
		if (end_chk && exp_q.size() != 0)
			report_fault("expected read words never arrived before the end of the run");
	end
end

endmodule

//--- tb_fbmem.sv
// Testbench top with DUT, random stimulus, frame buffer model and watchdog
module tb_fbmem import fbmem_pkg::*; ();

timeunit 1ns;
timeprecision 1ps;

localparam int BURST = 8;
localparam addr_t FB_BASE = 12'h000;
localparam int LINE_W = 64;
localparam int RECT_X = 8;
localparam int RECT_Y = 4;
localparam int RECT_W = 16;
localparam int RECT_H = 8;
localparam addr_t TEST_BASE = 12'h800;
localparam int TEST_LEN = 64;
localparam int AREA = RECT_W * RECT_H;
// Upper bound on external burst reads in the whole run
localparam int N_EXT = 240;
// Three fills, two self-tests and all external reads with a wide margin
localparam int WATCH_CYCLES = 4 * (6 * AREA
	+ 2 * (2 * TEST_LEN + (TEST_LEN / BURST) * (BURST + 4))
	+ N_EXT * (BURST + 16)) + 200;

logic CLOCK_50;
logic rst;
logic rect_start;
data_t rect_color;
logic rect_active;
logic test_start;
data_t test_seed;
logic test_done;
logic test_fail;
logic ext_req;
addr_t ext_addr;
logic ext_ack;
data_t ext_rdata;
logic ext_rvalid;

// Expectations toward the checker
logic exp_load;
logic [BURST*DATA_W-1:0] exp_burst;
logic stat_chk;
logic exp_active;
logic exp_done;
logic exp_fail;
logic end_chk;
int err_count;

// Frame buffer reference model
data_t model [1 << ADDR_W];

tb_clock clock_i (.CLOCK_50(CLOCK_50), .rst(rst));

fbmem_top #(
	.BURST(BURST), .FB_BASE(FB_BASE), .LINE_W(LINE_W),
	.RECT_X(RECT_X), .RECT_Y(RECT_Y), .RECT_W(RECT_W), .RECT_H(RECT_H),
	.TEST_BASE(TEST_BASE), .TEST_LEN(TEST_LEN)
) fbmem_top_i (
	.CLOCK_50(CLOCK_50), .rst(rst),
	.rect_start(rect_start), .rect_color(rect_color), .rect_active(rect_active),
	.test_start(test_start), .test_seed(test_seed),
	.test_done(test_done), .test_fail(test_fail),
	.ext_req(ext_req), .ext_addr(ext_addr), .ext_ack(ext_ack),
	.ext_rdata(ext_rdata), .ext_rvalid(ext_rvalid)
);

tb_checker #(.BURST(BURST)) checker_i (
	.CLOCK_50(CLOCK_50), .rst(rst),
	.ext_ack(ext_ack), .ext_rvalid(ext_rvalid), .ext_rdata(ext_rdata),
	.rect_active(rect_active), .test_done(test_done), .test_fail(test_fail),
	.exp_load(exp_load), .exp_burst(exp_burst),
	.stat_chk(stat_chk), .exp_active(exp_active), .exp_done(exp_done),
	.exp_fail(exp_fail), .end_chk(end_chk), .err_count(err_count)
);

// Fill rule applied row by row at the line stride
function automatic void fill_model(data_t c);
	for (int y = 0; y < RECT_H; y++)
		for (int x = 0; x < RECT_W; x++)
			model[addr_t'(int'(FB_BASE) + (RECT_Y + y) * LINE_W + RECT_X + x)] = c;
endfunction

// Test pattern rule of low address bits XOR seed
function automatic void pattern_model(data_t s);
	addr_t a;
	for (int i = 0; i < TEST_LEN; i++) begin
		a = addr_t'(int'(TEST_BASE) + i);
		model[a] = data_t'(a) ^ s;
	end
endfunction

task automatic read_burst(addr_t a);
	logic [BURST*DATA_W-1:0] words;
	ext_req <= 1'b1;
	ext_addr <= a;
	@(posedge CLOCK_50);
	while (!ext_ack)
		@(posedge CLOCK_50);
	ext_req <= 1'b0;
	// Word i lands in slot i
	words = '0;
	for (int i = 0; i < BURST; i++)
		words = {model[addr_t'(a + i)], words[BURST*DATA_W-1:DATA_W]};
	exp_burst <= words;
	exp_load <= 1'b1;
	@(posedge CLOCK_50);
	exp_load <= 1'b0;
	repeat (BURST + 1) @(posedge CLOCK_50);
endtask

task automatic read_range(addr_t a, int n);
	for (int k = 0; k < n; k += BURST) begin
		read_burst(addr_t'(a + k));
		repeat ($urandom_range(0, 3)) @(posedge CLOCK_50);
	end
endtask

// Rectangle plus one row above, one below and a burst either side
task automatic read_rect_area();
	for (int row = RECT_Y - 1; row <= RECT_Y + RECT_H; row++)
		read_range(addr_t'(int'(FB_BASE) + row * LINE_W + RECT_X - BURST),
			RECT_W + 2 * BURST);
endtask

task automatic start_engines(logic fill, data_t c, logic test, data_t s);
	rect_color <= c;
	test_seed <= s;
	rect_start <= fill;
	test_start <= test;
	@(posedge CLOCK_50);
	rect_start <= 1'b0;
	test_start <= 1'b0;
	@(posedge CLOCK_50);
endtask

task automatic check_status(logic act, logic dn, logic fl);
	exp_active <= act;
	exp_done <= dn;
	exp_fail <= fl;
	stat_chk <= 1'b1;
	@(posedge CLOCK_50);
	stat_chk <= 1'b0;
endtask

initial begin
	data_t c;
	data_t s;
	int k;
	void'($urandom(36586));
	for (int i = 0; i < (1 << ADDR_W); i++)
		model[addr_t'(i)] = '0;
	rect_start = 1'b0;
	rect_color = '0;
	test_start = 1'b0;
	test_seed = '0;
	ext_req = 1'b0;
	ext_addr = '0;
	exp_load = 1'b0;
	exp_burst = '0;
	stat_chk = 1'b0;
	exp_active = 1'b0;
	exp_done = 1'b0;
	exp_fail = 1'b0;
	end_chk = 1'b0;
	@(posedge CLOCK_50);
	while (rst)
		@(posedge CLOCK_50);

	// Idle after reset with memory still zero
	check_status(1'b0, 1'b0, 1'b0);
	read_range(addr_t'(int'(FB_BASE) + RECT_Y * LINE_W), 2 * BURST);
	read_range(TEST_BASE, 2 * BURST);

	// Single fill
	c = data_t'($urandom);
	start_engines(1'b1, c, 1'b0, '0);
	fill_model(c);
	while (rect_active)
		@(posedge CLOCK_50);
	check_status(1'b0, 1'b0, 1'b0);
	read_rect_area();

	// Single self-test
	s = data_t'($urandom);
	start_engines(1'b0, c, 1'b1, s);
	pattern_model(s);
	while (!test_done)
		@(posedge CLOCK_50);
	check_status(1'b0, 1'b1, 1'b0);
	read_range(TEST_BASE, TEST_LEN + BURST);

	// Fill and self-test together with reads kept clear of both regions
	c = data_t'($urandom);
	s = data_t'($urandom);
	start_engines(1'b1, c, 1'b1, s);
	fill_model(c);
	pattern_model(s);
	for (k = 0; k < 24 && (rect_active || !test_done); k++) begin
		read_burst(addr_t'(12'h400 + $urandom_range(0, 127) * 4));
		repeat ($urandom_range(0, 5)) @(posedge CLOCK_50);
	end
	while (rect_active)
		@(posedge CLOCK_50);
	while (!test_done)
		@(posedge CLOCK_50);
	check_status(1'b0, 1'b1, 1'b0);
	read_rect_area();
	read_range(TEST_BASE, TEST_LEN);

	// Refill where a second start mid-fill must not change the colour
	c = data_t'($urandom);
	start_engines(1'b1, c, 1'b0, s);
	fill_model(c);
	repeat (5) @(posedge CLOCK_50);
	start_engines(1'b1, ~c, 1'b0, s);
	while (rect_active)
		@(posedge CLOCK_50);
	check_status(1'b0, 1'b1, 1'b0);
	read_rect_area();

	end_chk <= 1'b1;
	@(posedge CLOCK_50);
	end_chk <= 1'b0;
	@(negedge CLOCK_50);
	$display("errors: %0d", err_count);
	if (err_count == 0)
		$display("all tests passed");
	else
		$display("tests failed");
	$finish;
end

// Watchdog
initial begin
	repeat (WATCH_CYCLES) @(posedge CLOCK_50);
	$display("run did not finish within %0d cycles", WATCH_CYCLES);
	$display("errors: %0d", err_count);
	$display("tests failed");
	$finish;
end

endmodule

//--- fbmem.f
fbmem_pkg.sv
mem_store.sv
mem_arbiter.sv
rect_fill.sv
mem_test.sv
fbmem_top.sv
tb_clock.sv
tb_checker.sv
tb_fbmem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_fbmem
RTL_TOP ?= fbmem_top
FILELIST ?= fbmem.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
